//--- audio_pkg.sv
// shared constants and types for the audio output peripheral
// register map, FIFO sizing, I2S and PDM timing, sample layout
`default_nettype none

package audio_pkg;

    // one channel and one stereo pair
    localparam int SAMPLE_W = 24;
    localparam int STEREO_W = 2 * SAMPLE_W;

    // 16 entries, level counts 0..16
    localparam int FIFO_LEN_BITS = 4;
    localparam int FIFO_DEPTH = 1 << FIFO_LEN_BITS;
    localparam int LEVEL_W = FIFO_LEN_BITS + 1;
    localparam logic [LEVEL_W-1:0] FIFO_FULL_LVL = LEVEL_W'(FIFO_DEPTH);

    // word offsets of the register map
    localparam logic [15:0] ADR_CTRL0       = 16'h0000;
    localparam logic [15:0] ADR_STAT0       = 16'h0004;
    localparam logic [15:0] ADR_FIFO_LOW    = 16'h0008;
    localparam logic [15:0] ADR_FIFO_LEVEL  = 16'h000C;
    localparam logic [15:0] ADR_AUDIO_LEFT  = 16'h0010;
    localparam logic [15:0] ADR_AUDIO_RIGHT = 16'h0014;

    // CTRL0 bits
    localparam int CTRL_RST_BIT      = 0;
    localparam int CTRL_DAC_MODE_BIT = 1;
    localparam int CTRL_DAC_EN_BIT   = 2;
    localparam int CTRL_I2S_EN_BIT   = 3;
    localparam int CTRL_W            = CTRL_I2S_EN_BIT + 1;

    // bclk half period in clk cycles, bits per channel slot
    localparam int BCLK_HALF = 4;
    localparam int BCLK_DIV_W = $clog2(BCLK_HALF);
    localparam logic [BCLK_DIV_W-1:0] BCLK_DIV_LAST = BCLK_DIV_W'(BCLK_HALF - 1);
    localparam int SLOT_BITS = 32;
    localparam int SLOT_CNT_W = $clog2(SLOT_BITS);
    localparam logic [SLOT_CNT_W-1:0] SLOT_LAST = SLOT_CNT_W'(SLOT_BITS - 1);

    // PDM sample period in clk cycles
    localparam int PDM_SAMPLE_CYCLES = 512;
    localparam int PDM_CNT_W = $clog2(PDM_SAMPLE_CYCLES);
    localparam logic [PDM_CNT_W-1:0] PDM_CNT_LAST = PDM_CNT_W'(PDM_SAMPLE_CYCLES - 1);

    typedef enum logic [1:0] {
        PH_IDLE,
        PH_LEFT,
        PH_RIGHT
    } i2s_phase_e;

    // right channel in the upper half
    typedef struct packed {
        logic [SAMPLE_W-1:0] right;
        logic [SAMPLE_W-1:0] left;
    } stereo_t;

endpackage

`default_nettype wire

//--- audio_stream_if.sv
// stereo sample stream from a source to a sink
// sample is valid while avail is high, the sink pulses take to consume it
`default_nettype none

interface audio_stream_if;

    // current head sample of the source
    audio_pkg::stereo_t sample;
    // source has a sample
    logic avail;
    // one-cycle consume pulse, source advances at the next edge
    logic take;

    modport source (
        output sample,
        output avail,
        input  take
    );

    modport sink (
        input  sample,
        input  avail,
        output take
    );

endinterface

`default_nettype wire

//--- sample_fifo_if.sv
// link between the register file and the sample FIFO
// push side from software, status flags back for readback and stall
`default_nettype none

interface sample_fifo_if;

    // one-cycle push of a full stereo pair
    logic push;
    audio_pkg::stereo_t push_data;
    // level, holds the FIFO empty
    logic flush;
    logic [audio_pkg::LEVEL_W-1:0] threshold;

    // registered status from the FIFO
    logic [audio_pkg::LEVEL_W-1:0] level;
    logic empty;
    logic full;
    logic low;

    modport regfile (
        output push, push_data, flush, threshold,
        input  level, empty, full, low
    );

    modport fifo (
        input  push, push_data, flush, threshold,
        output level, empty, full, low
    );

endinterface

`default_nettype wire

//--- audio_wb_regfile.sv
// Wishbone classic slave holding control, FIFO threshold and sample assembly
// a write with bit 31 set pushes the held stereo pair into the sample FIFO
`default_nettype none

module audio_wb_regfile (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        wb_cyc_i,
    input  wire logic        wb_stb_i,
    input  wire logic        wb_we_i,
    input  wire logic [15:0] wb_adr_i,
    input  wire logic [31:0] wb_dat_i,
    input  wire logic [3:0]  wb_sel_i,
    output logic      [31:0] wb_dat_o,
    output logic             wb_ack_o,
    sample_fifo_if.regfile   fifo,
    output logic             dac_mode_o,
    output logic             dac_enable_o,
    output logic             i2s_enable_o
);

    logic [audio_pkg::CTRL_W-1:0] ctrl0_q;
    logic [31:0] fifo_low_q;
    audio_pkg::stereo_t hold_q;
    logic push_arm_q;
    logic push_q;
    logic stall;
    logic access;
    logic is_sample_adr;
    logic [31:0] rd_data;

    // hold off while full or while a push is still on its way to the level
    assign stall = fifo.full || push_arm_q || push_q;
    // ack low for one cycle between accesses
    assign access = wb_cyc_i && wb_stb_i && !wb_ack_o && !stall;
    assign is_sample_adr = (wb_adr_i == audio_pkg::ADR_AUDIO_LEFT) ||
                           (wb_adr_i == audio_pkg::ADR_AUDIO_RIGHT);

    assign dac_mode_o   = ctrl0_q[audio_pkg::CTRL_DAC_MODE_BIT];
    assign dac_enable_o = ctrl0_q[audio_pkg::CTRL_DAC_EN_BIT];
    assign i2s_enable_o = ctrl0_q[audio_pkg::CTRL_I2S_EN_BIT];

    assign fifo.flush     = ctrl0_q[audio_pkg::CTRL_RST_BIT];
    assign fifo.threshold = fifo_low_q[audio_pkg::LEVEL_W-1:0];
    assign fifo.push      = push_q;
    assign fifo.push_data = hold_q;

    // readback mux, sample registers read as zero
    always_comb begin
        rd_data = '0;
        case (wb_adr_i)
            audio_pkg::ADR_CTRL0:      rd_data[audio_pkg::CTRL_W-1:0] = ctrl0_q;
            audio_pkg::ADR_STAT0:      rd_data[2:0] = {fifo.full, fifo.empty, fifo.low};
            audio_pkg::ADR_FIFO_LOW:   rd_data = fifo_low_q;
            audio_pkg::ADR_FIFO_LEVEL: rd_data[audio_pkg::LEVEL_W-1:0] = fifo.level;
            default:                   rd_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack_o <= 1'b0;
        end else begin
            wb_ack_o <= access;
        end
    end

    // read data lines up with ack
    always_ff @(posedge clk) begin
        wb_dat_o <= (access && !wb_we_i) ? rd_data : '0;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl0_q    <= '0;
            fifo_low_q <= '0;
            push_arm_q <= 1'b0;
            push_q     <= 1'b0;
        end else begin
            // push goes out one cycle after the acked write
            push_q     <= push_arm_q && !ctrl0_q[audio_pkg::CTRL_RST_BIT];
            push_arm_q <= access && wb_we_i && is_sample_adr &&
                          wb_sel_i[3] && wb_dat_i[31];
            if (access && wb_we_i) begin
                if (wb_adr_i == audio_pkg::ADR_CTRL0 && wb_sel_i[0]) begin
                    ctrl0_q <= wb_dat_i[audio_pkg::CTRL_W-1:0];
                end
                if (wb_adr_i == audio_pkg::ADR_FIFO_LOW) begin
                    // only selected bytes change
                    for (int b = 0; b < 4; b++) begin
                        if (wb_sel_i[b]) begin
                            fifo_low_q[8*b +: 8] <= wb_dat_i[8*b +: 8];
                        end
                    end
                end
            end
        end
    end

    // sample holding register, three data bytes per channel
    always_ff @(posedge clk) begin
        if (access && wb_we_i) begin
            for (int b = 0; b < 3; b++) begin
                if (wb_sel_i[b] && wb_adr_i == audio_pkg::ADR_AUDIO_LEFT) begin
                    hold_q.left[8*b +: 8] <= wb_dat_i[8*b +: 8];
                end
                if (wb_sel_i[b] && wb_adr_i == audio_pkg::ADR_AUDIO_RIGHT) begin
                    hold_q.right[8*b +: 8] <= wb_dat_i[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- audio_sample_fifo.sv
// 16-deep stereo sample FIFO between the register file and the output paths
// status flags are registered, flush from software holds it empty
`default_nettype none

module audio_sample_fifo (
    input  wire logic      clk,
    input  wire logic      rst,
    sample_fifo_if.fifo    ctrl,
    audio_stream_if.source out
);

    logic [audio_pkg::STEREO_W-1:0] mem [audio_pkg::FIFO_DEPTH];
    logic [audio_pkg::FIFO_LEN_BITS-1:0] wr_ptr;
    logic [audio_pkg::FIFO_LEN_BITS-1:0] rd_ptr;
    logic [audio_pkg::LEVEL_W-1:0] level_nxt;
    logic do_push;
    logic do_pop;

    // push while full is dropped, take while empty is ignored
    assign do_push = ctrl.push && !ctrl.full;
    assign do_pop  = out.take && !ctrl.empty;

    assign out.sample = audio_pkg::stereo_t'(mem[rd_ptr]);
    assign out.avail  = !ctrl.empty;

    // simultaneous push and pop keeps the level
    always_comb begin
        level_nxt = ctrl.level;
        if (do_push && !do_pop) begin
            level_nxt = ctrl.level + 1'b1;
        end else if (do_pop && !do_push) begin
            level_nxt = ctrl.level - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            ctrl.level <= '0;
            ctrl.empty <= 1'b1;
            ctrl.full  <= 1'b0;
            ctrl.low   <= 1'b0;
        end else if (ctrl.flush) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            ctrl.level <= '0;
            ctrl.empty <= 1'b1;
            ctrl.full  <= 1'b0;
            ctrl.low   <= (ctrl.threshold != '0);
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // flags from the next level so they match it
            ctrl.level <= level_nxt;
            ctrl.empty <= (level_nxt == '0);
            ctrl.full  <= (level_nxt == audio_pkg::FIFO_FULL_LVL);
            ctrl.low   <= (level_nxt < ctrl.threshold);
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (do_push && !ctrl.flush) begin
            mem[wr_ptr] <= ctrl.push_data;
        end
    end

endmodule

`default_nettype wire

//--- i2s_transmitter.sv
// I2S serializer, 32 bit clocks per slot, 24-bit words MSB first
// one sample taken per frame at the start of the left slot
`default_nettype none

module i2s_transmitter (
    input  wire logic    clk,
    input  wire logic    rst,
    input  wire logic    enable_i,
    audio_stream_if.sink in,
    output logic         bclk_o,
    output logic         lrclk_o,
    output logic         sdata_o
);

    logic [audio_pkg::BCLK_DIV_W-1:0] div_q;
    logic [audio_pkg::SLOT_CNT_W-1:0] bit_q;
    audio_pkg::i2s_phase_e phase_q;
    logic [audio_pkg::SAMPLE_W-1:0] right_q;
    logic [31:0] shift_q;
    logic fall_evt;
    logic slot_end;
    logic frame_start;
    audio_pkg::stereo_t cur;

    // bclk about to fall, data and lrclk change here
    assign fall_evt = (div_q == audio_pkg::BCLK_DIV_LAST) && bclk_o;
    assign slot_end = (bit_q == audio_pkg::SLOT_LAST);
    assign frame_start = fall_evt &&
        (phase_q == audio_pkg::PH_IDLE || (phase_q == audio_pkg::PH_RIGHT && slot_end));

    // take and latch on the same edge, so the FIFO pops what we used
    assign in.take = enable_i && frame_start;
    // underrun plays silence
    assign cur = in.avail ? in.sample : '0;

    always_ff @(posedge clk) begin
        if (rst || !enable_i) begin
            div_q   <= '0;
            bit_q   <= '0;
            phase_q <= audio_pkg::PH_IDLE;
            right_q <= '0;
            shift_q <= '0;
            bclk_o  <= 1'b0;
            lrclk_o <= 1'b0;
            sdata_o <= 1'b0;
        end else begin
            div_q <= div_q + 1'b1;
            if (div_q == audio_pkg::BCLK_DIV_LAST) begin
                div_q  <= '0;
                bclk_o <= ~bclk_o;
            end
            if (fall_evt) begin
                // one bclk delay, MSB shows on the fall after lrclk moves
                sdata_o <= shift_q[31];
                shift_q <= shift_q << 1;
                bit_q   <= bit_q + 1'b1;
                if (frame_start) begin
                    phase_q <= audio_pkg::PH_LEFT;
                    lrclk_o <= 1'b0;
                    bit_q   <= '0;
                    shift_q <= {cur.left, 8'h00};
                    right_q <= cur.right;
                end else if (phase_q == audio_pkg::PH_LEFT && slot_end) begin
                    phase_q <= audio_pkg::PH_RIGHT;
                    lrclk_o <= 1'b1;
                    bit_q   <= '0;
                    shift_q <= {right_q, 8'h00};
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- pdm_dac.sv
// first-order sigma-delta PDM of the mono mix of both channels
// new sample every PDM_SAMPLE_CYCLES clocks, accumulator carry is the bit
`default_nettype none

module pdm_dac (
    input  wire logic    clk,
    input  wire logic    rst,
    input  wire logic    enable_i,
    audio_stream_if.sink in,
    output logic         pdm_o
);

    logic [audio_pkg::PDM_CNT_W-1:0] period_q;
    logic signed [audio_pkg::SAMPLE_W:0] sum;
    logic [audio_pkg::SAMPLE_W-1:0] mix_q;
    logic [audio_pkg::SAMPLE_W-1:0] offset;
    logic [audio_pkg::SAMPLE_W-1:0] acc_q;
    logic [audio_pkg::SAMPLE_W:0] acc_sum;

    // take at the first enabled cycle, then once per period
    assign in.take = enable_i && (period_q == '0);

    // signed mean of left and right
    assign sum = $signed(in.sample.left) + $signed(in.sample.right);

    // two's complement to offset binary, zero sits at mid scale
    assign offset  = {~mix_q[audio_pkg::SAMPLE_W-1], mix_q[audio_pkg::SAMPLE_W-2:0]};
    assign acc_sum = {1'b0, acc_q} + {1'b0, offset};

    always_ff @(posedge clk) begin
        if (rst || !enable_i) begin
            period_q <= '0;
            mix_q    <= '0;
            acc_q    <= '0;
            pdm_o    <= 1'b0;
        end else begin
            period_q <= period_q + 1'b1;
            if (period_q == audio_pkg::PDM_CNT_LAST) begin
                period_q <= '0;
            end
            if (in.take) begin
                // underrun gives mid scale
                mix_q <= in.avail ? sum[audio_pkg::SAMPLE_W:1] : '0;
            end
            acc_q <= acc_sum[audio_pkg::SAMPLE_W-1:0];
            pdm_o <= acc_sum[audio_pkg::SAMPLE_W];
        end
    end

endmodule

`default_nettype wire

//--- audio_output_select.sv
// picks the active output path from the mode and enable bits
// only that path sees the FIFO stream, its take goes back to the FIFO
`default_nettype none

module audio_output_select (
    input  wire logic      clk,
    input  wire logic      rst,
    input  wire logic      dac_mode_i,
    input  wire logic      dac_enable_i,
    input  wire logic      i2s_enable_i,
    input  wire logic      soft_rst_i,
    audio_stream_if.sink   fifo_in,
    audio_stream_if.source i2s_out,
    audio_stream_if.source pdm_out,
    output logic           i2s_en_o,
    output logic           pdm_en_o
);

    // mode bit makes the two enables exclusive
    always_ff @(posedge clk) begin
        if (rst) begin
            i2s_en_o <= 1'b0;
            pdm_en_o <= 1'b0;
        end else begin
            i2s_en_o <= i2s_enable_i && !dac_mode_i && !soft_rst_i;
            pdm_en_o <= dac_enable_i && dac_mode_i && !soft_rst_i;
        end
    end

    // idle path sees no sample and no availability
    assign i2s_out.sample = i2s_en_o ? fifo_in.sample : '0;
    assign i2s_out.avail  = i2s_en_o && fifo_in.avail;
    assign pdm_out.sample = pdm_en_o ? fifo_in.sample : '0;
    assign pdm_out.avail  = pdm_en_o && fifo_in.avail;

    // take only from the enabled path
    assign fifo_in.take = (i2s_en_o && i2s_out.take) || (pdm_en_o && pdm_out.take);

endmodule

`default_nettype wire

//--- audio_top.sv
// audio output peripheral top, Wishbone slave in, I2S and PDM pins out
// instances and wiring only
`default_nettype none

module audio_top (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        wb_cyc_i,
    input  wire logic        wb_stb_i,
    input  wire logic        wb_we_i,
    input  wire logic [15:0] wb_adr_i,
    input  wire logic [31:0] wb_dat_i,
    input  wire logic [3:0]  wb_sel_i,
    output logic      [31:0] wb_dat_o,
    output logic             wb_ack_o,
    output logic             i2s_bclk_o,
    output logic             i2s_lrclk_o,
    output logic             i2s_sdata_o,
    output logic             pdm_o
);

    logic dac_mode;
    logic dac_enable;
    logic i2s_enable;
    logic i2s_en;
    logic pdm_en;

    sample_fifo_if  fifo_if ();
    // FIFO to selector, selector to each path
    audio_stream_if fifo_stream ();
    audio_stream_if i2s_stream ();
    audio_stream_if pdm_stream ();

    audio_wb_regfile u_regfile (
        .clk          (clk),
        .rst          (rst),
        .wb_cyc_i     (wb_cyc_i),
        .wb_stb_i     (wb_stb_i),
        .wb_we_i      (wb_we_i),
        .wb_adr_i     (wb_adr_i),
        .wb_dat_i     (wb_dat_i),
        .wb_sel_i     (wb_sel_i),
        .wb_dat_o     (wb_dat_o),
        .wb_ack_o     (wb_ack_o),
        .fifo         (fifo_if.regfile),
        .dac_mode_o   (dac_mode),
        .dac_enable_o (dac_enable),
        .i2s_enable_o (i2s_enable)
    );

    audio_sample_fifo u_fifo (
        .clk  (clk),
        .rst  (rst),
        .ctrl (fifo_if.fifo),
        .out  (fifo_stream.source)
    );

    // software reset also idles both paths
    audio_output_select u_select (
        .clk          (clk),
        .rst          (rst),
        .dac_mode_i   (dac_mode),
        .dac_enable_i (dac_enable),
        .i2s_enable_i (i2s_enable),
        .soft_rst_i   (fifo_if.flush),
        .fifo_in      (fifo_stream.sink),
        .i2s_out      (i2s_stream.source),
        .pdm_out      (pdm_stream.source),
        .i2s_en_o     (i2s_en),
        .pdm_en_o     (pdm_en)
    );

    i2s_transmitter u_i2s (
        .clk      (clk),
        .rst      (rst),
        .enable_i (i2s_en),
        .in       (i2s_stream.sink),
        .bclk_o   (i2s_bclk_o),
        .lrclk_o  (i2s_lrclk_o),
        .sdata_o  (i2s_sdata_o)
    );

    pdm_dac u_pdm (
        .clk      (clk),
        .rst      (rst),
        .enable_i (pdm_en),
        .in       (pdm_stream.sink),
        .pdm_o    (pdm_o)
    );

endmodule

`default_nettype wire

//--- audio_top_asserts.sv
// protocol and output checks bound into audio_top
// ack spacing, push against flush, exclusive paths, quiet pins when idle
`default_nettype none

module audio_top_asserts (
    input wire logic clk,
    input wire logic rst,
    input wire logic ack_i,
    input wire logic push_i,
    input wire logic flush_i,
    input wire logic i2s_en_i,
    input wire logic pdm_en_i,
    input wire logic bclk_i,
    input wire logic lrclk_i,
    input wire logic sdata_i,
    input wire logic pdm_i
);

    // ack drops for a cycle between accesses
    ack_gap: assert property (@(posedge clk) disable iff (rst)
        !(ack_i && $past(ack_i)))
        else $error("wb ack high two cycles in a row");

    push_flush: assert property (@(posedge clk) disable iff (rst)
        !(push_i && flush_i))
        else $error("push during flush");

    one_path: assert property (@(posedge clk) disable iff (rst)
        !(i2s_en_i && pdm_en_i))
        else $error("both output paths enabled");

    // pins clear one cycle after the last enable drops
    quiet_pins: assert property (@(posedge clk) disable iff (rst)
        (!i2s_en_i && !pdm_en_i && !$past(i2s_en_i) && !$past(pdm_en_i)) |->
        (!bclk_i && !lrclk_i && !sdata_i && !pdm_i))
        else $error("output pins active with both paths disabled");

endmodule

bind audio_top audio_top_asserts u_asserts (
    .clk      (clk),
    .rst      (rst),
    .ack_i    (wb_ack_o),
    .push_i   (fifo_if.push),
    .flush_i  (fifo_if.flush),
    .i2s_en_i (i2s_en),
    .pdm_en_i (pdm_en),
    .bclk_i   (i2s_bclk_o),
    .lrclk_i  (i2s_lrclk_o),
    .sdata_i  (i2s_sdata_o),
    .pdm_i    (pdm_o)
);

`default_nettype wire

//--- tb_audio_top.sv
// directed testbench for the audio output peripheral
// Wishbone register and FIFO tests, I2S frame decode, PDM pulse density
`default_nettype none

module tb_audio_top;

    localparam int WB_TIMEOUT = 64;
    localparam int FRAME_TIMEOUT = 2000;

    logic        clk;
    logic        rst;
    logic        wb_cyc_i;
    logic        wb_stb_i;
    logic        wb_we_i;
    logic [15:0] wb_adr_i;
    logic [31:0] wb_dat_i;
    logic [3:0]  wb_sel_i;
    logic [31:0] wb_dat_o;
    logic        wb_ack_o;
    logic        i2s_bclk_o;
    logic        i2s_lrclk_o;
    logic        i2s_sdata_o;
    logic        pdm_o;

    integer seed;
    int err_count;
    int check_count;
    int test_start_errs;
    // I2S decoder state, kept across frame captures
    logic [31:0] dec_shift;
    logic dec_prev_lr;
    logic dec_prev_bclk;

    audio_top dut (
        .clk         (clk),
        .rst         (rst),
        .wb_cyc_i    (wb_cyc_i),
        .wb_stb_i    (wb_stb_i),
        .wb_we_i     (wb_we_i),
        .wb_adr_i    (wb_adr_i),
        .wb_dat_i    (wb_dat_i),
        .wb_sel_i    (wb_sel_i),
        .wb_dat_o    (wb_dat_o),
        .wb_ack_o    (wb_ack_o),
        .i2s_bclk_o  (i2s_bclk_o),
        .i2s_lrclk_o (i2s_lrclk_o),
        .i2s_sdata_o (i2s_sdata_o),
        .pdm_o       (pdm_o)
    );

    always #50 clk = ~clk;

    task automatic report_error(input string msg);
        err_count++;
        $display("Error: %s", msg);
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_level(input logic [audio_pkg::LEVEL_W-1:0] got,
                               input logic [audio_pkg::LEVEL_W-1:0] exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("Fail FIFO_LEVEL: got 0x%h, expected 0x%h", got, exp);
        end
    endtask

    task automatic check_sample(input string name, input audio_pkg::stereo_t got,
                                input audio_pkg::stereo_t exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic finish_test(input string name);
        if (err_count == test_start_errs) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, err_count - test_start_errs);
        end
        test_start_errs = err_count;
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        repeat (3) @(negedge clk);
        rst = 1'b0;
    endtask

    // one classic cycle, drops stb once ack is seen or the wait runs out
    task automatic wb_cycle(input logic we, input logic [15:0] adr, input logic [31:0] dat,
                            input logic [3:0] sel, output logic [31:0] rdata, output bit ok);
        int waited;
        waited = 0;
        ok = 1'b0;
        rdata = '0;
        @(negedge clk);
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr_i = adr;
        wb_dat_i = dat;
        wb_sel_i = sel;
        while (!ok && waited < WB_TIMEOUT) begin
            @(negedge clk);
            waited++;
            if (wb_ack_o) begin
                ok = 1'b1;
                rdata = wb_dat_o;
            end
        end
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
    endtask

    task automatic wb_write(input logic [15:0] adr, input logic [31:0] dat,
                            input logic [3:0] sel);
        logic [31:0] unused;
        bit ok;
        wb_cycle(1'b1, adr, dat, sel, unused, ok);
        if (!ok) begin
            report_error($sformatf("no ack for write to 0x%h in %0d cycles", adr, WB_TIMEOUT));
        end
    endtask

    task automatic wb_read(input logic [15:0] adr, output logic [31:0] data);
        bit ok;
        wb_cycle(1'b0, adr, '0, 4'hF, data, ok);
        if (!ok) begin
            report_error($sformatf("no ack for read of 0x%h in %0d cycles", adr, WB_TIMEOUT));
        end
    endtask

    task automatic read_check_word(input string name, input logic [15:0] adr,
                                   input logic [31:0] exp);
        logic [31:0] data;
        wb_read(adr, data);
        check_word(name, data, exp);
    endtask

    task automatic read_check_level(input logic [audio_pkg::LEVEL_W-1:0] exp);
        logic [31:0] data;
        wb_read(audio_pkg::ADR_FIFO_LEVEL, data);
        check_level(data[audio_pkg::LEVEL_W-1:0], exp);
    endtask

    // left without bit 31, right with bit 31 and sel[3] to push
    task automatic push_sample(input audio_pkg::stereo_t s);
        wb_write(audio_pkg::ADR_AUDIO_LEFT, {8'h00, s.left}, 4'b0111);
        wb_write(audio_pkg::ADR_AUDIO_RIGHT, {8'h80, s.right}, 4'b1111);
    endtask

    task automatic make_sample(output audio_pkg::stereo_t s);
        logic [31:0] r;
        r = $random(seed);
        s.left = r[23:0];
        r = $random(seed);
        s.right = r[23:0];
    endtask

    // slot bits sampled on rising bclk, MSB is the second bit of a slot
    task automatic capture_frame(output audio_pkg::stereo_t frame, output bit ok);
        int waited;
        bit got_left;
        logic lr;
        waited = 0;
        ok = 1'b0;
        got_left = 1'b0;
        frame = '0;
        while (!ok && waited < FRAME_TIMEOUT) begin
            @(negedge clk);
            waited++;
            if (i2s_bclk_o && !dec_prev_bclk) begin
                lr = i2s_lrclk_o;
                if (lr != dec_prev_lr) begin
                    if (!dec_prev_lr) begin
                        frame.left = dec_shift[30:7];
                        got_left = 1'b1;
                    end else if (got_left) begin
                        frame.right = dec_shift[30:7];
                        ok = 1'b1;
                    end
                    dec_shift = {31'b0, i2s_sdata_o};
                end else begin
                    dec_shift = {dec_shift[30:0], i2s_sdata_o};
                end
                dec_prev_lr = lr;
            end
            dec_prev_bclk = i2s_bclk_o;
        end
    endtask

    task automatic count_pdm_ones(output int ones, output int i2s_active);
        ones = 0;
        i2s_active = 0;
        for (int i = 0; i < audio_pkg::PDM_SAMPLE_CYCLES; i++) begin
            if (pdm_o) begin
                ones++;
            end
            if (i2s_bclk_o || i2s_lrclk_o || i2s_sdata_o) begin
                i2s_active++;
            end
            @(negedge clk);
        end
    endtask

    task automatic register_test();
        read_check_word("CTRL0", audio_pkg::ADR_CTRL0, 32'h0);
        read_check_word("FIFO_LOW", audio_pkg::ADR_FIFO_LOW, 32'h0);
        read_check_level(5'd0);
        // empty set, full and low clear
        read_check_word("STAT0", audio_pkg::ADR_STAT0, 32'h2);
        wb_write(audio_pkg::ADR_FIFO_LOW, 32'hAABBCCDD, 4'b0001);
        read_check_word("FIFO_LOW", audio_pkg::ADR_FIFO_LOW, 32'h000000DD);
        wb_write(audio_pkg::ADR_FIFO_LOW, 32'h11223344, 4'b0100);
        read_check_word("FIFO_LOW", audio_pkg::ADR_FIFO_LOW, 32'h002200DD);
        wb_write(audio_pkg::ADR_AUDIO_LEFT, 32'h00123456, 4'b0111);
        read_check_word("AUDIO_LEFT", audio_pkg::ADR_AUDIO_LEFT, 32'h0);
        finish_test("register access");
    endtask

    task automatic fifo_fill_test();
        audio_pkg::stereo_t s;
        logic [31:0] rdata;
        bit ok;
        wb_write(audio_pkg::ADR_FIFO_LOW, 32'd5, 4'b1111);
        for (int i = 0; i < 3; i++) begin
            make_sample(s);
            push_sample(s);
        end
        read_check_level(5'd3);
        // 3 below threshold 5, low only
        read_check_word("STAT0", audio_pkg::ADR_STAT0, 32'h1);
        for (int i = 3; i < 15; i++) begin
            make_sample(s);
            push_sample(s);
        end
        read_check_level(5'd15);
        read_check_word("STAT0", audio_pkg::ADR_STAT0, 32'h0);
        make_sample(s);
        push_sample(s);
        // full FIFO holds off every access
        wb_cycle(1'b0, audio_pkg::ADR_STAT0, '0, 4'hF, rdata, ok);
        if (ok) begin
            report_error("STAT0 read acknowledged while the FIFO was full");
        end
        wb_cycle(1'b1, audio_pkg::ADR_FIFO_LOW, 32'd3, 4'hF, rdata, ok);
        if (ok) begin
            report_error("write acknowledged while the FIFO was full");
        end else begin
            $display("write held off with the FIFO full, no ack in %0d cycles", WB_TIMEOUT);
        end
        finish_test("fifo fill and back-pressure");
    endtask

    task automatic soft_reset_test();
        audio_pkg::stereo_t s;
        for (int i = 0; i < 4; i++) begin
            make_sample(s);
            push_sample(s);
        end
        read_check_level(5'd4);
        wb_write(audio_pkg::ADR_CTRL0, 32'h1, 4'b0001);
        read_check_level(5'd0);
        read_check_word("STAT0", audio_pkg::ADR_STAT0, 32'h2);
        wb_write(audio_pkg::ADR_CTRL0, 32'h0, 4'b0001);
        make_sample(s);
        push_sample(s);
        read_check_level(5'd1);
        read_check_word("STAT0", audio_pkg::ADR_STAT0, 32'h0);
        finish_test("software reset");
    endtask

    task automatic i2s_test();
        audio_pkg::stereo_t pushed [3];
        audio_pkg::stereo_t frame;
        bit ok;
        wb_write(audio_pkg::ADR_CTRL0, 32'h1, 4'b0001);
        wb_write(audio_pkg::ADR_CTRL0, 32'h0, 4'b0001);
        for (int i = 0; i < 3; i++) begin
            make_sample(pushed[i]);
            push_sample(pushed[i]);
        end
        dec_shift = '0;
        dec_prev_lr = 1'b0;
        dec_prev_bclk = 1'b0;
        // I2S enable, mode bit clear
        wb_write(audio_pkg::ADR_CTRL0, 32'h8, 4'b0001);
        for (int f = 0; f < 4; f++) begin
            capture_frame(frame, ok);
            if (!ok) begin
                report_error($sformatf("no complete I2S frame %0d within %0d cycles",
                                       f, FRAME_TIMEOUT));
                break;
            end
            // drained FIFO plays silence
            check_sample($sformatf("i2s frame %0d", f), frame, (f < 3) ? pushed[f] : '0);
        end
        wb_write(audio_pkg::ADR_CTRL0, 32'h0, 4'b0001);
        read_check_level(5'd0);
        finish_test("i2s output");
    endtask

    task automatic pdm_test();
        audio_pkg::stereo_t s;
        int ones;
        int i2s_active;
        s.left = 24'h7FFFFF;
        s.right = 24'h7FFFFF;
        push_sample(s);
        push_sample('0);
        // builtin DAC mode plus DAC enable
        wb_write(audio_pkg::ADR_CTRL0, 32'h6, 4'b0001);
        // enable register, then the first take, then the new mix reaches pdm_o
        repeat (3) @(negedge clk);
        count_pdm_ones(ones, i2s_active);
        check_count++;
        if (ones < 500) begin
            err_count++;
            $display("Fail pdm_o ones: got 0x%h, expected at least 0x%h", ones, 500);
        end
        if (i2s_active != 0) begin
            report_error("I2S pins active while the PDM path was selected");
        end
        count_pdm_ones(ones, i2s_active);
        check_count++;
        if (ones < 254 || ones > 258) begin
            err_count++;
            $display("Fail pdm_o ones: got 0x%h, expected 0x%h +-2", ones, 256);
        end
        if (i2s_active != 0) begin
            report_error("I2S pins active while the PDM path was selected");
        end
        wb_write(audio_pkg::ADR_CTRL0, 32'h0, 4'b0001);
        finish_test("pdm output");
    endtask

    initial begin
        seed = 41;
        err_count = 0;
        check_count = 0;
        test_start_errs = 0;
        clk = 1'b0;
        rst = 1'b1;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i = 1'b0;
        wb_adr_i = '0;
        wb_dat_i = '0;
        wb_sel_i = '0;
        dec_shift = '0;
        dec_prev_lr = 1'b0;
        dec_prev_bclk = 1'b0;
        apply_reset();
        register_test();
        fifo_fill_test();
        // only a hard reset frees a full FIFO with both paths off
        apply_reset();
        soft_reset_test();
        i2s_test();
        pdm_test();
        $display("checks %0d, errors %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // overall limit on run time
    initial begin
        repeat (40000) @(posedge clk);
        $display("simulation stopped by the watchdog");
        $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
audio_pkg.sv
audio_stream_if.sv
sample_fifo_if.sv
audio_wb_regfile.sv
audio_sample_fifo.sv
i2s_transmitter.sv
pdm_dac.sv
audio_output_select.sv
audio_top.sv
audio_top_asserts.sv
tb_audio_top.sv

//--- run.sh
#!/bin/sh
# build and run the audio peripheral testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module tb_audio_top -o sim_audio
./obj_dir/sim_audio | tee sim.log
if grep -q "TB FAILED" sim.log; then
    exit 1
fi
# a run stopped by an assertion never reaches the closing line
if ! grep -q "TB PASSED" sim.log; then
    exit 1
fi
exit 0
